// ==== mc_pkg.sv ====
package mc_pkg;

	parameter int address_width = 10;	// word address
	parameter int col_width = 4;	// column bits inside a burst
	parameter int burst_addr_width = address_width - col_width;
	parameter int data_width = 32;
	parameter int tag_width = 6;
	parameter int index_width = tag_width + 1;	// client number sits above the tag
	parameter int burst_length = 16;	// beats per burst, one per column
	parameter int max_merge = 8;	// requests before an open burst closes

	// per slot status word seen by the timing controller
	// msb is the slot type, the rest is the burst state
	parameter int status_width = 4;

	typedef enum logic {
		read_req,
		write_req
	} req_type_e;

	typedef enum logic [2:0] {
		cmd_none,
		cmd_activate,
		cmd_read,
		cmd_write,
		cmd_precharge
	} command_e;

	// life of one burst slot
	typedef enum logic [2:0] {
		empty,
		started_filling,
		almost_done,	// one more merge fits
		full,	// waiting for the timing controller
		in_service,
		returning_data
	} burst_state_e;

	// upper bits pick the burst
	function automatic logic [burst_addr_width-1:0] burst_addr(
		input logic [address_width-1:0] addr
	);
		return addr[address_width-1:col_width];
	endfunction

endpackage

// ==== req_arbiter.sv ====
`timescale 1ns/1ps

module req_arbiter #(
	parameter int no_of_bursts = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic req_0,
	input  logic req_1,
	input  mc_pkg::req_type_e req_type_0,
	input  mc_pkg::req_type_e req_type_1,
	input  logic [mc_pkg::address_width-1:0] req_addr_0,
	input  logic [mc_pkg::address_width-1:0] req_addr_1,
	input  logic [mc_pkg::data_width-1:0] req_data_0,
	input  logic [mc_pkg::data_width-1:0] req_data_1,
	input  logic [mc_pkg::tag_width-1:0] req_tag_0,
	input  logic [mc_pkg::tag_width-1:0] req_tag_1,
	input  logic [$clog2(no_of_bursts):0] free_slots,
	output logic grant_0,
	output logic grant_1,
	output logic arb_valid,
	output mc_pkg::req_type_e arb_type,
	output logic [mc_pkg::address_width-1:0] arb_addr,
	output logic [mc_pkg::data_width-1:0] arb_data,
	output logic [mc_pkg::index_width-1:0] arb_index
);
	import mc_pkg::*;

	logic last_winner;	// 1 when client 1 got the last grant
	logic [tag_width-1:0] win_tag;

	// one grant per cycle, none while every slot is taken
	always_comb begin
		grant_0 = 1'b0;
		grant_1 = 1'b0;
		if (free_slots != '0) begin
			if (req_0 && req_1) begin
				grant_0 = last_winner;	// other client's turn
				grant_1 = !last_winner;
			end else begin
				grant_0 = req_0;
				grant_1 = req_1;
			end
		end
	end

	assign arb_valid = grant_0 | grant_1;

	// winner's fields, client 0 when nobody wins
	always_comb begin
		if (grant_1) begin
			arb_type = req_type_1;
			arb_addr = req_addr_1;
			arb_data = req_data_1;
			win_tag = req_tag_1;
		end else begin
			arb_type = req_type_0;
			arb_addr = req_addr_0;
			arb_data = req_data_0;
			win_tag = req_tag_0;
		end
	end

	assign arb_index = {grant_1, win_tag};	// client number on top

	always_ff @(posedge clk) begin
		if (rst_n) begin
			last_winner <= 1'b1;	// client 0 goes first
		end else if (arb_valid) begin
			last_winner <= grant_1;
		end
	end

endmodule

// ==== burst_handler.sv ====
`timescale 1ns/1ps

module burst_handler #(
	parameter int no_of_bursts = 4,
	parameter int rd_to_data = 4,
	parameter int wr_to_data = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  logic arb_valid,
	input  mc_pkg::req_type_e arb_type,
	input  logic [mc_pkg::address_width-1:0] arb_addr,
	input  logic [mc_pkg::data_width-1:0] arb_data,
	input  logic [mc_pkg::index_width-1:0] arb_index,
	input  mc_pkg::command_e cmd,
	input  logic [$clog2(no_of_bursts)-1:0] cmd_index,
	input  logic [mc_pkg::data_width-1:0] mem_rdata,
	output logic [$clog2(no_of_bursts):0] free_slots,
	output logic [no_of_bursts-1:0][mc_pkg::status_width-1:0] burst_state,
	output logic [no_of_bursts-1:0][mc_pkg::burst_addr_width-1:0] slot_addr,
	output logic mem_we,
	output logic [mc_pkg::address_width-1:0] mem_addr,
	output logic [mc_pkg::data_width-1:0] mem_wdata,
	output logic xfer_done,
	output logic resp_valid,
	output mc_pkg::req_type_e resp_type,
	output logic [mc_pkg::data_width-1:0] resp_data,
	output logic [mc_pkg::index_width-1:0] resp_index
);
	import mc_pkg::*;

	localparam int slot_w = $clog2(no_of_bursts);
	localparam int max_wait = (rd_to_data > wr_to_data) ? rd_to_data : wr_to_data;
	localparam int wait_w = $clog2(max_wait + 1);

	typedef enum logic [1:0] {
		x_idle,
		x_wait,	// command to first beat
		x_beats
	} xfer_state_e;

	req_type_e slot_type [no_of_bursts];
	burst_state_e slot_st [no_of_bursts];
	logic [burst_length-1:0] slot_mask [no_of_bursts];	// columns holding a request
	logic [data_width-1:0] slot_data [no_of_bursts][burst_length];
	logic [index_width-1:0] slot_idx [no_of_bursts][burst_length];

	logic open_valid;	// a slot is still filling
	logic [slot_w-1:0] open_slot;
	logic [$clog2(max_merge+1)-1:0] merge_cnt;
	logic merge_hit;
	logic open_new;
	logic [slot_w-1:0] new_slot;
	logic [slot_w-1:0] dest_slot;
	logic [col_width-1:0] arb_col;

	xfer_state_e x_state;
	logic [slot_w-1:0] x_slot;
	req_type_e x_type;
	logic [wait_w-1:0] wait_cnt;
	logic [wait_w-1:0] wait_target;
	logic [col_width-1:0] beat_cnt;
	logic cap_valid;	// read word on mem_rdata this cycle
	logic [col_width-1:0] cap_col;

	logic ret_found;
	logic [slot_w-1:0] ret_slot;
	logic [col_width-1:0] ret_col;
	logic ret_last;

	assign arb_col = arb_addr[col_width-1:0];
	assign merge_hit = open_valid && (slot_addr[open_slot] == burst_addr(arb_addr))
		&& (slot_type[open_slot] == arb_type);
	assign open_new = arb_valid && !merge_hit;
	assign dest_slot = merge_hit ? open_slot : new_slot;

	// free count, lowest empty slot, status words
	always_comb begin
		free_slots = '0;
		new_slot = '0;
		for (int i = no_of_bursts - 1; i >= 0; i--) begin
			burst_state[i] = {slot_type[i], slot_st[i]};
			if (slot_st[i] == empty) begin
				free_slots = free_slots + 1'b1;
				new_slot = slot_w'(i);
			end
		end
	end

	// lowest returning slot, lowest column first
	always_comb begin
		ret_found = 1'b0;
		ret_slot = '0;
		ret_col = '0;
		for (int i = no_of_bursts - 1; i >= 0; i--) begin
			if (slot_st[i] == returning_data) begin
				ret_found = 1'b1;
				ret_slot = slot_w'(i);
			end
		end
		for (int c = burst_length - 1; c >= 0; c--) begin
			if (slot_mask[ret_slot][c]) begin
				ret_col = col_width'(c);
			end
		end
		ret_last = (slot_mask[ret_slot] & ~(burst_length'(1) << ret_col)) == '0;
	end

	assign wait_target = (x_type == write_req) ? wait_w'(wr_to_data - 2) : wait_w'(rd_to_data - 2);

	// array side, one column per beat
	assign mem_addr = {slot_addr[x_slot], beat_cnt};
	assign mem_we = (x_state == x_beats) && (x_type == write_req) && slot_mask[x_slot][beat_cnt];
	assign mem_wdata = slot_data[x_slot][beat_cnt];

	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < no_of_bursts; i++) begin
				slot_st[i] <= empty;
				slot_mask[i] <= '0;
			end
			open_valid <= 1'b0;
			open_slot <= '0;
			merge_cnt <= '0;
		end else begin
			if (arb_valid && merge_hit) begin
				slot_mask[open_slot][arb_col] <= 1'b1;
				merge_cnt <= merge_cnt + 1'b1;
				if (merge_cnt == max_merge - 1) begin
					slot_st[open_slot] <= full;	// merge limit
					open_valid <= 1'b0;
				end else if (merge_cnt == max_merge - 2) begin
					slot_st[open_slot] <= almost_done;
				end
			end else begin
				if (open_valid) begin
					slot_st[open_slot] <= full;	// gap, other address or other type
					open_valid <= 1'b0;
				end
				if (open_new) begin
					slot_st[new_slot] <= started_filling;
					slot_mask[new_slot] <= burst_length'(1) << arb_col;
					open_slot <= new_slot;
					open_valid <= 1'b1;
					merge_cnt <= 'd1;
				end
			end
			case (cmd)
				cmd_activate: slot_st[cmd_index] <= in_service;
				cmd_precharge: slot_st[cmd_index] <= returning_data;
				default: ;
			endcase
			if (ret_found) begin
				slot_mask[ret_slot][ret_col] <= 1'b0;	// one response per cycle
				if (ret_last) begin
					slot_st[ret_slot] <= empty;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			x_state <= x_idle;
			wait_cnt <= '0;
			beat_cnt <= '0;
			xfer_done <= 1'b0;
			cap_valid <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			xfer_done <= 1'b0;
			cap_valid <= (x_state == x_beats) && (x_type == read_req);
			resp_valid <= ret_found;
			case (x_state)
				x_idle: begin
					if (cmd == cmd_read || cmd == cmd_write) begin
						x_state <= x_wait;
						wait_cnt <= '0;
					end
				end
				x_wait: begin
					if (wait_cnt == wait_target) begin
						x_state <= x_beats;
						beat_cnt <= '0;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				x_beats: begin
					beat_cnt <= beat_cnt + 1'b1;
					if (beat_cnt == col_width'(burst_length - 1)) begin
						x_state <= x_idle;
						xfer_done <= 1'b1;	// high with the last read capture
					end
				end
				default: x_state <= x_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (open_new) begin
			slot_type[new_slot] <= arb_type;
			slot_addr[new_slot] <= burst_addr(arb_addr);
		end
		if (arb_valid) begin
			slot_idx[dest_slot][arb_col] <= arb_index;
			if (arb_type == write_req) begin
				slot_data[dest_slot][arb_col] <= arb_data;
			end
		end
		if (cap_valid && slot_mask[x_slot][cap_col]) begin
			slot_data[x_slot][cap_col] <= mem_rdata;	// lands a cycle after its address
		end
		if (cmd == cmd_read || cmd == cmd_write) begin
			x_slot <= cmd_index;
			x_type <= (cmd == cmd_write) ? write_req : read_req;
		end
		cap_col <= beat_cnt;
		resp_type <= slot_type[ret_slot];
		resp_data <= slot_data[ret_slot][ret_col];
		resp_index <= slot_idx[ret_slot][ret_col];
	end

endmodule

// ==== timing_controller.sv ====
`timescale 1ns/1ps

module timing_controller #(
	parameter int no_of_bursts = 4,
	parameter int act_to_cmd = 3
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [no_of_bursts-1:0][mc_pkg::status_width-1:0] burst_state,
	input  logic [no_of_bursts-1:0][mc_pkg::burst_addr_width-1:0] slot_addr,
	input  logic xfer_done,
	output mc_pkg::command_e cmd,
	output logic [$clog2(no_of_bursts)-1:0] cmd_index,
	output logic [mc_pkg::burst_addr_width-1:0] cmd_row
);
	import mc_pkg::*;

	localparam int slot_w = $clog2(no_of_bursts);
	localparam int row_w = $clog2(act_to_cmd);	// act_to_cmd of 2 or more

	typedef enum logic [2:0] {
		tc_idle,
		tc_activate,	// activate on cmd
		tc_row_wait,
		tc_access,	// read or write on cmd
		tc_data,	// beats run in the handler
		tc_precharge
	} tc_state_e;

	tc_state_e state;
	logic [row_w-1:0] row_cnt;
	req_type_e serve_type;
	logic full_found;
	logic [slot_w-1:0] full_slot;

	// lowest full slot
	always_comb begin
		full_found = 1'b0;
		full_slot = '0;
		for (int i = no_of_bursts - 1; i >= 0; i--) begin
			if (burst_state_e'(burst_state[i][status_width-2:0]) == full) begin
				full_found = 1'b1;
				full_slot = slot_w'(i);
			end
		end
	end

	// each command state lasts one cycle
	always_comb begin
		case (state)
			tc_activate: cmd = cmd_activate;
			tc_access: cmd = (serve_type == write_req) ? cmd_write : cmd_read;
			tc_precharge: cmd = cmd_precharge;
			default: cmd = cmd_none;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state <= tc_idle;
			row_cnt <= '0;
		end else begin
			case (state)
				tc_idle: begin
					if (full_found) begin
						state <= tc_activate;
					end
				end
				tc_activate: begin
					state <= tc_row_wait;
					row_cnt <= '0;
				end
				tc_row_wait: begin
					if (row_cnt == row_w'(act_to_cmd - 2)) begin
						state <= tc_access;	// act_to_cmd after activate
					end else begin
						row_cnt <= row_cnt + 1'b1;
					end
				end
				tc_access: state <= tc_data;
				tc_data: begin
					if (xfer_done) begin
						state <= tc_precharge;
					end
				end
				default: state <= tc_idle;	// after precharge
			endcase
		end
	end

	// slot picked in idle, held until precharge
	always_ff @(posedge clk) begin
		if (state == tc_idle && full_found) begin
			cmd_index <= full_slot;
			cmd_row <= slot_addr[full_slot];
			serve_type <= req_type_e'(burst_state[full_slot][status_width-1]);
		end
	end

endmodule

// ==== dram_bank_model.sv ====
`timescale 1ns/1ps

module dram_bank_model (
	input  logic clk,
	input  logic rst_n,
	input  mc_pkg::command_e cmd,
	input  logic [mc_pkg::burst_addr_width-1:0] cmd_row,
	input  logic mem_we,
	input  logic [mc_pkg::address_width-1:0] mem_addr,
	input  logic [mc_pkg::data_width-1:0] mem_wdata,
	output logic [mc_pkg::data_width-1:0] mem_rdata,
	output logic protocol_error
);
	import mc_pkg::*;

	logic [data_width-1:0] mem [2**address_width];
	logic row_open;
	logic [burst_addr_width-1:0] open_row;
	logic bad_cmd;
	logic bad_write;

	// activate on open row, or access to a closed or other row
	assign bad_cmd = (cmd == cmd_activate && row_open)
		|| ((cmd == cmd_read || cmd == cmd_write) && (!row_open || cmd_row != open_row));
	assign bad_write = mem_we && (!row_open || burst_addr(mem_addr) != open_row);

	always_ff @(posedge clk) begin
		if (mem_we) begin
			mem[mem_addr] <= mem_wdata;
		end
		mem_rdata <= mem[mem_addr];	// registered read
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			row_open <= 1'b0;
			open_row <= '0;
			protocol_error <= 1'b0;
		end else begin
			if (cmd == cmd_activate) begin
				row_open <= 1'b1;
				open_row <= cmd_row;
			end else if (cmd == cmd_precharge) begin
				row_open <= 1'b0;
			end
			if (bad_cmd || bad_write) begin
				protocol_error <= 1'b1;	// sticky
			end
		end
	end

endmodule

// ==== mem_ctrl_top.sv ====
`timescale 1ns/1ps

module mem_ctrl_top #(
	parameter int no_of_bursts = 4,
	parameter int rd_to_data = 4,
	parameter int wr_to_data = 2,
	parameter int act_to_cmd = 3
) (
	input  logic clk,
	input  logic rst_n,
	input  logic req_0,
	input  logic req_1,
	input  mc_pkg::req_type_e req_type_0,
	input  mc_pkg::req_type_e req_type_1,
	input  logic [mc_pkg::address_width-1:0] req_addr_0,
	input  logic [mc_pkg::address_width-1:0] req_addr_1,
	input  logic [mc_pkg::data_width-1:0] req_data_0,
	input  logic [mc_pkg::data_width-1:0] req_data_1,
	input  logic [mc_pkg::tag_width-1:0] req_tag_0,
	input  logic [mc_pkg::tag_width-1:0] req_tag_1,
	output logic grant_0,
	output logic grant_1,
	output logic resp_valid,
	output mc_pkg::req_type_e resp_type,
	output logic [mc_pkg::data_width-1:0] resp_data,
	output logic [mc_pkg::index_width-1:0] resp_index,
	output logic protocol_error
);
	import mc_pkg::*;

	logic arb_valid;	// arbiter to handler
	req_type_e arb_type;
	logic [address_width-1:0] arb_addr;
	logic [data_width-1:0] arb_data;
	logic [index_width-1:0] arb_index;
	logic [$clog2(no_of_bursts):0] free_slots;
	logic [no_of_bursts-1:0][status_width-1:0] burst_state;	// handler to scheduler
	logic [no_of_bursts-1:0][burst_addr_width-1:0] slot_addr;
	logic xfer_done;
	command_e cmd;
	logic [$clog2(no_of_bursts)-1:0] cmd_index;
	logic [burst_addr_width-1:0] cmd_row;
	logic mem_we;	// handler to array
	logic [address_width-1:0] mem_addr;
	logic [data_width-1:0] mem_wdata;
	logic [data_width-1:0] mem_rdata;

	req_arbiter #(.no_of_bursts(no_of_bursts)) u_arbiter (.*);

	burst_handler #(
		.no_of_bursts(no_of_bursts),
		.rd_to_data(rd_to_data),
		.wr_to_data(wr_to_data)
	) u_handler (.*);

	timing_controller #(
		.no_of_bursts(no_of_bursts),
		.act_to_cmd(act_to_cmd)
	) u_timing (.*);

	dram_bank_model u_bank (.*);

endmodule

// ==== mem_ctrl_sva.sv ====
`timescale 1ns/1ps

module mem_ctrl_sva (
	input logic clk,
	input logic rst_n,
	input logic grant_0,
	input logic grant_1,
	input mc_pkg::command_e cmd,
	input logic protocol_error,
	input logic resp_valid
);
	import mc_pkg::*;

	// one grant per cycle
	grant_single: assert property (@(posedge clk) disable iff (rst_n) !(grant_0 && grant_1))
		else $error("both clients granted in one cycle");

	cmd_pulse: assert property (@(posedge clk) disable iff (rst_n)
		(cmd != cmd_none) |=> (cmd == cmd_none))	// every command is a single cycle
		else $error("command held for more than one cycle");

	bank_ok: assert property (@(posedge clk) disable iff (rst_n) !protocol_error)
		else $error("array flagged a protocol error");

	resp_known: assert property (@(posedge clk) disable iff (rst_n) !$isunknown(resp_valid))
		else $error("resp_valid unknown");

endmodule

bind mem_ctrl_top mem_ctrl_sva u_sva (
	.clk(clk),
	.rst_n(rst_n),
	.grant_0(grant_0),
	.grant_1(grant_1),
	.cmd(cmd),
	.protocol_error(protocol_error),
	.resp_valid(resp_valid)
);

// ==== tb_mem_ctrl.sv ====
`timescale 1ns/1ps

module tb_mem_ctrl;
	import mc_pkg::*;

	localparam int clk_period = 20;
	localparam int total_reqs = 8 + 8 + 20 + 12 + 48;	// all requests the tests issue
	localparam int cycles_per_req = 200;

	logic clk;
	logic rst_n;
	logic req_0;
	logic req_1;
	req_type_e req_type_0;
	req_type_e req_type_1;
	logic [address_width-1:0] req_addr_0;
	logic [address_width-1:0] req_addr_1;
	logic [data_width-1:0] req_data_0;
	logic [data_width-1:0] req_data_1;
	logic [tag_width-1:0] req_tag_0;
	logic [tag_width-1:0] req_tag_1;
	logic grant_0;
	logic grant_1;
	logic resp_valid;
	req_type_e resp_type;
	logic [data_width-1:0] resp_data;
	logic [index_width-1:0] resp_index;
	logic protocol_error;

	// scoreboard memory and outstanding requests, keyed by index
	logic [data_width-1:0] sb_mem [2**address_width];
	bit pend [2**index_width];
	req_type_e exp_type [2**index_width];
	logic [data_width-1:0] exp_data [2**index_width];
	logic [address_width-1:0] exp_addr [2**index_width];
	int outstanding;
	int tag_cnt [2];
	int errors;
	int act_cnt;	// activates seen
	bit log_grants;
	bit grant_log [$];	// winning client per grant
	logic [index_width-1:0] resp_log [$];
	string test_name;
	integer seed;

	mem_ctrl_top #(
		.no_of_bursts(4),
		.rd_to_data(4),
		.wr_to_data(2),
		.act_to_cmd(3)
	) u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// hung run guard
	initial begin
		repeat (total_reqs * cycles_per_req + 2000) @(posedge clk);
		$display("watchdog expired with %0d requests still outstanding", outstanding);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("** Error %s %s: expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	// hold one request until granted, then drop it
	task automatic issue(input int c, input req_type_e t, input logic [address_width-1:0] a,
		input logic [data_width-1:0] d);
		logic [tag_width-1:0] tag;
		logic [index_width-1:0] idx;
		tag = tag_width'(tag_cnt[c]);
		tag_cnt[c]++;
		idx = {c[0], tag};
		if (pend[idx]) begin
			errors++;
			$display("%s: index %h reused while still outstanding", test_name, idx);
		end
		if (t == write_req) sb_mem[a] = d;	// reads see the last write issued
		pend[idx] = 1'b1;
		exp_type[idx] = t;
		exp_addr[idx] = a;
		exp_data[idx] = (t == write_req) ? d : sb_mem[a];
		outstanding++;
		if (c == 0) begin
			req_type_0 = t;
			req_addr_0 = a;
			req_data_0 = d;
			req_tag_0 = tag;
			req_0 = 1'b1;
		end else begin
			req_type_1 = t;
			req_addr_1 = a;
			req_data_1 = d;
			req_tag_1 = tag;
			req_1 = 1'b1;
		end
		do @(negedge clk); while (c == 0 ? !grant_0 : !grant_1);	// grant is combinational
		@(posedge clk);
		#2;
		if (c == 0) req_0 = 1'b0;
		else req_1 = 1'b0;
	endtask

	task automatic drain();
		while (outstanding != 0) @(negedge clk);
		@(posedge clk);
		#2;
	endtask

	// response monitor, checks type and data against the scoreboard
	always @(negedge clk) begin
		if (!rst_n && resp_valid) begin
			if (!pend[resp_index]) begin
				errors++;
				$display("%s: response for index %h that is not outstanding", test_name, resp_index);
			end else begin
				compare("type", 32'(exp_type[resp_index]), 32'(resp_type));
				compare("data", exp_data[resp_index], resp_data);
				pend[resp_index] = 1'b0;
				outstanding--;
				resp_log.push_back(resp_index);
			end
		end
		if (log_grants && (grant_0 || grant_1)) grant_log.push_back(grant_1);
		if (u_dut.cmd == cmd_activate) act_cnt++;	// one per burst served
	end

	task automatic write_then_read();
		test_name = "write_then_read";
		for (int k = 0; k < 4; k++) issue(0, write_req, {6'd5, 4'(k)}, $random(seed));
		drain();
		resp_log.delete();
		act_cnt = 0;
		issue(0, read_req, {6'd5, 4'd3}, '0);	// columns out of order on purpose
		issue(0, read_req, {6'd5, 4'd1}, '0);
		issue(0, read_req, {6'd5, 4'd0}, '0);
		issue(0, read_req, {6'd5, 4'd2}, '0);
		drain();
		compare("read bursts", 1, act_cnt);	// back-to-back reads share one slot
		for (int k = 0; k < resp_log.size(); k++) begin
			compare("read column", k, 32'(exp_addr[resp_log[k]][col_width-1:0]));
		end
	endtask

	task automatic burst_split();
		test_name = "burst_split";
		act_cnt = 0;
		issue(0, write_req, {6'd10, 4'd0}, $random(seed));
		issue(0, write_req, {6'd11, 4'd0}, $random(seed));
		issue(0, write_req, {6'd10, 4'd1}, $random(seed));
		issue(0, write_req, {6'd11, 4'd1}, $random(seed));
		issue(0, read_req, {6'd5, 4'd0}, '0);	// type change, settled data
		issue(0, read_req, {6'd5, 4'd1}, '0);
		issue(0, write_req, {6'd10, 4'd2}, $random(seed));
		issue(0, write_req, {6'd11, 4'd2}, $random(seed));
		drain();
		if (act_cnt < 7) begin	// only the two reads may share a slot
			errors++;
			$display("%s: eight split requests went out as only %0d bursts", test_name, act_cnt);
		end
	endtask

	task automatic merge_limit();
		test_name = "merge_limit";
		act_cnt = 0;
		for (int k = 0; k < 10; k++) issue(1, write_req, {6'd9, 4'(k)}, $random(seed));
		drain();
		if (act_cnt < 2) begin
			errors++;
			$display("%s: ten merged writes went out as %0d burst", test_name, act_cnt);
		end
		for (int k = 0; k < 10; k++) issue(1, read_req, {6'd9, 4'(k)}, '0);
		drain();
	endtask

	task automatic arbitration();
		test_name = "arbitration";
		resp_log.delete();
		grant_log.delete();
		log_grants = 1'b1;
		fork
			for (int k = 0; k < 6; k++) issue(0, write_req, {6'd20, 4'(k)}, $random(seed));
			for (int k = 0; k < 6; k++) issue(1, write_req, {6'd21, 4'(k)}, $random(seed));
		join
		log_grants = 1'b0;
		drain();
		compare("grant count", 12, grant_log.size());
		for (int k = 1; k < grant_log.size(); k++) begin
			if (grant_log[k] == grant_log[k-1]) begin
				errors++;
				$display("%s: client %0d granted twice in a row", test_name, grant_log[k]);
			end
		end
		foreach (resp_log[k]) begin	// client 1 owns burst 21
			compare("client", 32'(exp_addr[resp_log[k]][9:4] == 6'd21), 32'(resp_log[k][6]));
		end
	endtask

	task automatic saturation();
		test_name = "saturation";
		fork
			for (int k = 0; k < 24; k++) begin
				issue(0, write_req, {6'd32 + 6'($random(seed) & 15), 4'(k)}, $random(seed));
				repeat ($random(seed) & 1) begin	// random idle cycle
					@(posedge clk);
					#2;
				end
			end
			for (int k = 0; k < 24; k++) issue(1, read_req, {6'd9, 4'(k % 10)}, '0);
		join
		drain();
		compare("protocol_error", 0, 32'(protocol_error));
	endtask

	initial begin
		seed = 32'h92f6_330b;
		errors = 0;
		outstanding = 0;
		tag_cnt[0] = 0;
		tag_cnt[1] = 0;
		act_cnt = 0;
		log_grants = 1'b0;
		rst_n = 1'b1;	// high means reset
		req_0 = 1'b0;
		req_1 = 1'b0;
		req_type_0 = read_req;
		req_type_1 = read_req;
		req_addr_0 = '0;
		req_addr_1 = '0;
		req_data_0 = '0;
		req_data_1 = '0;
		req_tag_0 = '0;
		req_tag_1 = '0;
		test_name = "reset";
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b0;
		compare("grants", 0, 32'({grant_0, grant_1}));
		compare("resp_valid", 0, 32'(resp_valid));
		write_then_read();
		burst_split();
		merge_limit();
		arbitration();
		saturation();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
mc_pkg.sv
req_arbiter.sv
burst_handler.sv
timing_controller.sv
dram_bank_model.sv
mem_ctrl_top.sv
mem_ctrl_sva.sv
tb_mem_ctrl.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_mem_ctrl
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
